//--- source/barrel_pkg.sv
`default_nettype none

package barrel_pkg;

   // Screen coordinates
   localparam int COORD_W = 11;

   // Lanes and launch spacing
   localparam int NUM_LANES = 5;
   localparam int LANE_W = 3;

   // Clock cycles scaled down for simulation
   localparam int LAUNCH_GAP = 16;
   localparam int GAP_W = $clog2(LAUNCH_GAP);

   // Round
   localparam int MAX_LIVES = 3;
   localparam int LIVES_W = 2;

   // Barrel motion in pixels
   localparam int BARREL_TOP_Y = 64;
   localparam int BARREL_FLOOR_Y = 704;
   localparam int BARREL_STEP = 8;

   // Sprite sizes in pixels
   localparam int BARREL_SIZE = 32;
   localparam int PLAYER_W = 48;
   localparam int PLAYER_H = 64;

   // Top-left corner of a sprite
   typedef struct packed {
      logic [COORD_W-1:0] x;
      logic [COORD_W-1:0] y;
   } point_t;

   // One lane's barrel as seen by the rest of the game
   typedef struct packed {
      logic   active;
      point_t pos;
   } barrel_t;

endpackage

`default_nettype wire

//--- source/barrel_launcher.sv
`default_nettype none

module barrel_launcher (
   input  logic                                clk65MHz,
   input  logic                                reset,
   input  logic                                game_on,
   input  logic                                launch,
   input  logic [barrel_pkg::COORD_W-1:0]      launch_x,
   input  logic [barrel_pkg::NUM_LANES-1:0]    busy,
   output logic [barrel_pkg::NUM_LANES-1:0]    drop,
   output logic [barrel_pkg::COORD_W-1:0]      drop_x
);

   import barrel_pkg::*;

   logic [GAP_W-1:0]  gap_cnt;
   logic [LANE_W-1:0] free_idx;
   logic              free_any;
   logic              accept;

   // Lowest idle lane wins
   always_comb begin
      free_idx = '0;
      free_any = 1'b0;
      for (int i = NUM_LANES - 1; i >= 0; i--) begin
         if (!busy[i]) begin
            free_idx = LANE_W'(i);
            free_any = 1'b1;
         end
      end
   end

   assign accept = launch && game_on && (gap_cnt == '0) && free_any;

   // A launch exactly LAUNCH_GAP cycles later sees the counter at zero
   always_ff @(posedge clk65MHz) begin
      if (reset) begin
         drop    <= '0;
         gap_cnt <= '0;
      end else begin
         if (accept) begin
            drop    <= NUM_LANES'(1) << free_idx;
            gap_cnt <= GAP_W'(LAUNCH_GAP - 1);
         end else begin
            drop <= '0;
            if (gap_cnt != '0) begin
               gap_cnt <= gap_cnt - 1'b1;
            end
         end
      end
   end

   // Column travels with the drop pulse
   always_ff @(posedge clk65MHz) begin
      if (accept) begin
         drop_x <= launch_x;
      end
   end

   a_drop_onehot: assert property (
      @(posedge clk65MHz) disable iff (reset)
      $onehot0(drop)
   ) else $error("drop is not one-hot");

   // Lane must still be idle when its drop arrives
   a_drop_free_lane: assert property (
      @(posedge clk65MHz) disable iff (reset)
      (drop & busy) == '0
   ) else $error("drop targets a busy lane");

endmodule

`default_nettype wire

//--- source/barrel_lane.sv
`default_nettype none

module barrel_lane (
   input  logic                           clk65MHz,
   input  logic                           reset,
   input  logic                           game_on,
   input  logic                           drop,
   input  logic [barrel_pkg::COORD_W-1:0] drop_x,
   input  barrel_pkg::point_t             player,
   output barrel_pkg::barrel_t            barrel,
   output logic                           hit
);

   import barrel_pkg::*;

   logic               active;
   point_t             pos;
   logic [COORD_W:0]   next_y;
   logic               at_floor;
   logic [COORD_W:0]   barrel_right;
   logic [COORD_W:0]   barrel_bottom;
   logic [COORD_W:0]   player_right;
   logic [COORD_W:0]   player_bottom;
   logic               overlap;

   // One extra bit so edges near the screen border do not wrap
   assign next_y   = {1'b0, pos.y} + (COORD_W + 1)'(BARREL_STEP);
   assign at_floor = next_y >= (COORD_W + 1)'(BARREL_FLOOR_Y);

   assign barrel_right  = {1'b0, pos.x} + (COORD_W + 1)'(BARREL_SIZE);
   assign barrel_bottom = {1'b0, pos.y} + (COORD_W + 1)'(BARREL_SIZE);
   assign player_right  = {1'b0, player.x} + (COORD_W + 1)'(PLAYER_W);
   assign player_bottom = {1'b0, player.y} + (COORD_W + 1)'(PLAYER_H);

   // Box test on both axes
   assign overlap = ({1'b0, pos.x} < player_right) && ({1'b0, player.x} < barrel_right) &&
                    ({1'b0, pos.y} < player_bottom) && ({1'b0, player.y} < barrel_bottom);

   always_ff @(posedge clk65MHz) begin
      if (reset) begin
         active <= 1'b0;
         hit    <= 1'b0;
      end else if (!game_on) begin
         active <= 1'b0;
         hit    <= 1'b0;
      end else if (drop) begin
         active <= 1'b1;
         hit    <= 1'b0;
      end else if (active) begin
         if (overlap) begin
            active <= 1'b0;
            hit    <= 1'b1;
         end else begin
            active <= !at_floor;
            hit    <= 1'b0;
         end
      end else begin
         hit <= 1'b0;
      end
   end

   // Position only matters while active
   always_ff @(posedge clk65MHz) begin
      if (drop) begin
         pos.x <= drop_x;
         pos.y <= COORD_W'(BARREL_TOP_Y);
      end else if (active) begin
         pos.y <= next_y[COORD_W-1:0];
      end
   end

   assign barrel.active = active;
   assign barrel.pos    = pos;

   a_hit_from_active: assert property (
      @(posedge clk65MHz) disable iff (reset)
      hit |-> $past(active)
   ) else $error("hit without an active barrel");

   a_above_floor: assert property (
      @(posedge clk65MHz) disable iff (reset)
      active |-> (pos.y < COORD_W'(BARREL_FLOOR_Y))
   ) else $error("active barrel at or below the floor");

endmodule

`default_nettype wire

//--- source/game_control.sv
`default_nettype none

module game_control (
   input  logic                             clk65MHz,
   input  logic                             reset,
   input  logic                             start,
   input  logic [barrel_pkg::NUM_LANES-1:0] hit,
   output logic                             game_on,
   output logic [barrel_pkg::LIVES_W-1:0]   lives
);

   import barrel_pkg::*;

   typedef enum logic {
      ST_IDLE,
      ST_PLAY
   } state_t;

   state_t state;
   logic   any_hit;

   // Several lanes hitting together cost a single life
   assign any_hit = |hit;

   always_ff @(posedge clk65MHz) begin
      if (reset) begin
         state <= ST_IDLE;
         lives <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state <= ST_PLAY;
                  lives <= LIVES_W'(MAX_LIVES);
               end
            end
            ST_PLAY: begin
               if (any_hit) begin
                  if (lives <= LIVES_W'(1)) begin
                     lives <= '0;
                     state <= ST_IDLE;
                  end else begin
                     lives <= lives - 1'b1;
                  end
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   assign game_on = (state == ST_PLAY);

   // Round ends on the same edge the last life goes
   a_lives_in_play: assert property (
      @(posedge clk65MHz) disable iff (reset)
      game_on |-> (lives != '0)
   ) else $error("round running with no lives left");

endmodule

`default_nettype wire

//--- source/barrel_game.sv
`default_nettype none

module barrel_game (
   input  logic                                  clk65MHz,
   input  logic                                  reset,
   input  logic                                  start,
   input  logic                                  launch,
   input  barrel_pkg::point_t                    kong_pos,
   input  barrel_pkg::point_t                    donkey_pos,
   output barrel_pkg::barrel_t [barrel_pkg::NUM_LANES-1:0] barrels,
   output logic [barrel_pkg::LIVES_W-1:0]        lives,
   output logic                                  game_on,
   output logic [barrel_pkg::NUM_LANES-1:0]      hit
);

   import barrel_pkg::*;

   logic [NUM_LANES-1:0] drop;
   logic [NUM_LANES-1:0] busy;
   logic [COORD_W-1:0]   drop_x;

   // Kong throws from its own column
   barrel_launcher u_barrel_launcher (
      .clk65MHz,
      .reset,
      .game_on,
      .launch,
      .launch_x(kong_pos.x),
      .busy,
      .drop,
      .drop_x
   );

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      barrel_lane u_barrel_lane (
         .clk65MHz,
         .reset,
         .game_on,
         .drop(drop[i]),
         .drop_x,
         .player(donkey_pos),
         .barrel(barrels[i]),
         .hit(hit[i])
      );

      assign busy[i] = barrels[i].active;
   end

   game_control u_game_control (
      .clk65MHz,
      .reset,
      .start,
      .hit,
      .game_on,
      .lives
   );

endmodule

`default_nettype wire

//--- test/barrel_game_tb.sv
`default_nettype none

module barrel_game_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import barrel_pkg::*;

   typedef enum int {
      CHK_ACTIVE,
      CHK_X,
      CHK_Y,
      CHK_HIT,
      CHK_LIVES,
      CHK_GAME_ON
   } check_kind_t;

   // One expected value due at the falling edge of a given cycle
   typedef struct packed {
      int          cyc;
      check_kind_t what;
      int          lane;
      int          value;
   } check_t;

   logic                 clk65MHz = 1'b0;
   logic                 reset = 1'b1;
   logic                 start = 1'b0;
   logic                 launch = 1'b0;
   point_t               kong_pos = '0;
   point_t               donkey_pos = '0;
   barrel_t [NUM_LANES-1:0] barrels;
   logic [LIVES_W-1:0]   lives;
   logic                 game_on;
   logic [NUM_LANES-1:0] hit;

   int     cycle = 0;
   int     errors = 0;
   int     errors_before = 0;
   int     tests_passed = 0;
   int     tests_failed = 0;
   check_t pending[$];
   check_t later[$];

   barrel_game barrel_game_inst (
      .clk65MHz(clk65MHz),
      .reset(reset),
      .start(start),
      .launch(launch),
      .kong_pos(kong_pos),
      .donkey_pos(donkey_pos),
      .barrels(barrels),
      .lives(lives),
      .game_on(game_on),
      .hit(hit)
   );

   always #10 clk65MHz = ~clk65MHz;

   // Index of the last rising edge as seen at the falling edge
   always @(posedge clk65MHz) cycle <= cycle + 1;

   // Edges after the launch edge until hit shows, or -1 for a miss
   function automatic int hit_delay(input logic [COORD_W-1:0] col, input point_t player);
      int bx;
      int px;
      int py;
      int y;
      bx = int'(col);
      px = int'(player.x);
      py = int'(player.y);
      if (!(bx < px + PLAYER_W && px < bx + BARREL_SIZE)) begin
         return -1;
      end
      for (int n = 0; n < (BARREL_FLOOR_Y - BARREL_TOP_Y) / BARREL_STEP; n++) begin
         y = BARREL_TOP_Y + n * BARREL_STEP;
         if (y < py + PLAYER_H && py < y + BARREL_SIZE) begin
            return n + 3;
         end
      end
      return -1;
   endfunction

   function automatic logic [31:0] observed(input check_t c);
      case (c.what)
         CHK_ACTIVE: return 32'(barrels[c.lane].active);
         CHK_X:      return 32'(barrels[c.lane].pos.x);
         CHK_Y:      return 32'(barrels[c.lane].pos.y);
         CHK_HIT:    return 32'(hit[c.lane]);
         CHK_LIVES:  return 32'(lives);
         default:    return 32'(game_on);
      endcase
   endfunction

   function automatic string signal_name(input check_t c);
      case (c.what)
         CHK_ACTIVE: return $sformatf("barrels[%0d].active", c.lane);
         CHK_X:      return $sformatf("barrels[%0d].pos.x", c.lane);
         CHK_Y:      return $sformatf("barrels[%0d].pos.y", c.lane);
         CHK_HIT:    return $sformatf("hit[%0d]", c.lane);
         CHK_LIVES:  return "lives";
         default:    return "game_on";
      endcase
   endfunction

   always @(negedge clk65MHz) begin
      later.delete();
      foreach (pending[i]) begin
         if (pending[i].cyc == cycle) begin
            if (observed(pending[i]) !== pending[i].value) begin
               $display("FAIL t=%0t %s got %0d expected %0d", $time,
                        signal_name(pending[i]), observed(pending[i]), pending[i].value);
               errors++;
            end
         end else if (pending[i].cyc < cycle) begin
            $display("Expected value of %s for cycle %0d was scheduled too late",
                     signal_name(pending[i]), pending[i].cyc);
            errors++;
         end else begin
            later.push_back(pending[i]);
         end
      end
      pending = later;
   end

   function automatic void push_check(input int cyc, input check_kind_t what,
                                      input int lane, input int value);
      pending.push_back(check_t'{cyc: cyc, what: what, lane: lane, value: value});
   endfunction

   function automatic void expect_idle(input int cyc);
      push_check(cyc, CHK_GAME_ON, 0, 0);
      push_check(cyc, CHK_LIVES, 0, 0);
      for (int i = 0; i < NUM_LANES; i++) begin
         push_check(cyc, CHK_ACTIVE, i, 0);
         push_check(cyc, CHK_HIT, i, 0);
      end
   endfunction

   // Full life of one barrel launched on edge t0
   function automatic void expect_barrel(input int t0, input int lane,
                                         input logic [COORD_W-1:0] col, input int d);
      int last;
      last = (d < 0) ? t0 + 1 + (BARREL_FLOOR_Y - BARREL_TOP_Y) / BARREL_STEP : t0 + d - 1;
      push_check(t0 + 2, CHK_X, lane, int'(col));
      for (int c = t0 + 2; c <= last; c++) begin
         push_check(c, CHK_ACTIVE, lane, 1);
         push_check(c, CHK_Y, lane, BARREL_TOP_Y + (c - t0 - 2) * BARREL_STEP);
         push_check(c, CHK_HIT, lane, 0);
      end
      push_check(last + 1, CHK_ACTIVE, lane, 0);
      push_check(last + 1, CHK_HIT, lane, (d < 0) ? 0 : 1);
      push_check(last + 2, CHK_HIT, lane, 0);
   endfunction

   function automatic logic [COORD_W-1:0] random_column();
      return COORD_W'($urandom_range(1000));
   endfunction

   function automatic point_t far_player(input logic [COORD_W-1:0] col);
      point_t p;
      if (col < 500) begin
         p.x = COORD_W'(int'(col) + 100 + int'($urandom_range(400)));
      end else begin
         p.x = COORD_W'(int'(col) - 100 - int'($urandom_range(400)));
      end
      p.y = COORD_W'($urandom_range(700));
      return p;
   endfunction

   function automatic point_t player_under(input logic [COORD_W-1:0] col);
      point_t p;
      p.x = col + COORD_W'($urandom_range(24));
      p.y = COORD_W'($urandom_range(400, 200));
      return p;
   endfunction

   task automatic pulse_launch(input logic [COORD_W-1:0] col, output int t0);
      @(posedge clk65MHz);
      launch     <= 1'b1;
      kong_pos.x <= col;
      t0 = cycle + 1;
      @(posedge clk65MHz);
      launch <= 1'b0;
   endtask

   task automatic pulse_start(output int t0);
      @(posedge clk65MHz);
      start <= 1'b1;
      t0 = cycle + 1;
      @(posedge clk65MHz);
      start <= 1'b0;
   endtask

   task automatic place_player(input point_t p);
      @(posedge clk65MHz);
      donkey_pos <= p;
   endtask

   task automatic wait_checks_done(input int limit);
      int n;
      n = 0;
      while (pending.size() > 0 && n < limit) begin
         @(posedge clk65MHz);
         n++;
      end
      if (pending.size() > 0) begin
         $display("Timed out after %0d cycles with %0d checks still waiting",
                  limit, pending.size());
         errors++;
         pending.delete();
      end
   endtask

   task automatic end_test(input string name);
      if (errors == errors_before) begin
         $display("test %s: passed", name);
         tests_passed++;
      end else begin
         $display("test %s: failed with %0d errors", name, errors - errors_before);
         tests_failed++;
      end
      errors_before = errors;
   endtask

   // Barrel hits the player and costs one life
   task automatic run_hit(input int lives_after);
      logic [COORD_W-1:0] col;
      point_t             player;
      int                 t0;
      int                 d;
      col = random_column();
      player = player_under(col);
      place_player(player);
      pulse_launch(col, t0);
      d = hit_delay(col, player);
      if (d < 0) begin
         $display("Player placed under column %0d but no hit is predicted", col);
         errors++;
      end else begin
         expect_barrel(t0, 0, col, d);
         push_check(t0 + d + 1, CHK_LIVES, 0, lives_after);
         push_check(t0 + d + 1, CHK_GAME_ON, 0, 1);
      end
      wait_checks_done(200);
   endtask

   initial begin
      int                 t0;
      int                 ta;
      int                 tb;
      int                 d;
      logic [COORD_W-1:0] col;
      logic [COORD_W-1:0] col_a;
      point_t             player;
      void'($urandom(32'hd411_b86b));
      repeat (16) @(posedge clk65MHz);
      reset <= 1'b0;

      expect_idle(cycle + 1);
      pulse_launch(random_column(), t0);
      expect_idle(t0 + 2);
      expect_idle(t0 + 3);
      wait_checks_done(50);
      end_test("after reset");

      pulse_start(t0);
      push_check(t0 + 1, CHK_GAME_ON, 0, 1);
      push_check(t0 + 1, CHK_LIVES, 0, MAX_LIVES);
      wait_checks_done(20);
      pulse_start(t0);
      push_check(t0 + 2, CHK_GAME_ON, 0, 1);
      push_check(t0 + 2, CHK_LIVES, 0, MAX_LIVES);
      wait_checks_done(20);
      end_test("start");

      col = random_column();
      player = far_player(col);
      place_player(player);
      pulse_launch(col, t0);
      expect_barrel(t0, 0, col, hit_delay(col, player));
      push_check(t0 + 2, CHK_ACTIVE, 1, 0);
      push_check(t0 + 2 + (BARREL_FLOOR_Y - BARREL_TOP_Y) / BARREL_STEP, CHK_LIVES, 0,
                 MAX_LIVES);
      wait_checks_done(200);
      end_test("miss");

      // Player parked far right of every column
      player.x = COORD_W'(1800);
      player.y = '0;
      place_player(player);
      ta = 0;
      for (int k = 0; k < NUM_LANES; k++) begin
         col = random_column();
         pulse_launch(col, t0);
         if (k == 0) begin
            ta = t0;
         end
         expect_barrel(t0, k, col, hit_delay(col, player));
         if (k < NUM_LANES - 1) begin
            repeat (LAUNCH_GAP / 2 - 2) @(posedge clk65MHz);
            pulse_launch(random_column(), tb);
            push_check(tb + 2, CHK_ACTIVE, k + 1, 0);
            repeat (LAUNCH_GAP / 2 - 2) @(posedge clk65MHz);
         end else begin
            repeat (LAUNCH_GAP - 2) @(posedge clk65MHz);
         end
      end
      // Sixth launch with every lane busy
      pulse_launch(random_column(), tb);
      push_check(ta + 83, CHK_ACTIVE, 0, 0);
      push_check(ta + 84, CHK_ACTIVE, 0, 0);
      push_check(ta + 84, CHK_LIVES, 0, MAX_LIVES);
      wait_checks_done(200);
      end_test("gap and lane choice");

      run_hit(MAX_LIVES - 1);
      // Start during play keeps the reduced life count
      pulse_start(t0);
      push_check(t0 + 2, CHK_GAME_ON, 0, 1);
      push_check(t0 + 2, CHK_LIVES, 0, MAX_LIVES - 1);
      wait_checks_done(20);
      end_test("hit");

      run_hit(MAX_LIVES - 2);
      col = random_column();
      player = player_under(col);
      col_a = (col < 500) ? col + COORD_W'(400) : col - COORD_W'(400);
      place_player(player);
      pulse_launch(col_a, ta);
      repeat (LAUNCH_GAP - 2) @(posedge clk65MHz);
      pulse_launch(col, tb);
      d = hit_delay(col, player);
      expect_barrel(tb, 1, col, d);
      push_check(tb + d + 1, CHK_LIVES, 0, 0);
      push_check(tb + d + 1, CHK_GAME_ON, 0, 0);
      push_check(tb + d + 1, CHK_ACTIVE, 0, 1);
      push_check(tb + d + 2, CHK_ACTIVE, 0, 0);
      expect_idle(tb + d + 3);
      wait_checks_done(200);
      pulse_launch(random_column(), t0);
      expect_idle(t0 + 2);
      expect_idle(t0 + 3);
      wait_checks_done(50);
      pulse_start(t0);
      push_check(t0 + 1, CHK_GAME_ON, 0, 1);
      push_check(t0 + 1, CHK_LIVES, 0, MAX_LIVES);
      wait_checks_done(20);
      end_test("game over");

      $display("Tests passed: %0d, failed: %0d, errors: %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
source/barrel_pkg.sv
source/barrel_launcher.sv
source/barrel_lane.sv
source/game_control.sv
source/barrel_game.sv
test/barrel_game_tb.sv

//--- Makefile
# Verilator simulation of the barrel game

VERILATOR ?= verilator
TOP       ?= barrel_game_tb
FILE_LIST ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
